//--- verilog/exu_alu_config.svh
`ifndef EXU_ALU_CONFIG_SVH
`define EXU_ALU_CONFIG_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

`define ALU_XLEN     32
`define ALU_PC_W     32
`define ALU_RFIDX_W  5   // x0..x31

// Width of the decoded op field from dispatch
`define ALU_OP_W     4

// Link value is pc plus one 32-bit instruction
`define ALU_LINK_INC 4

`endif

//--- verilog/exu_alu_pkg.sv
package exu_alu_pkg;

`include "exu_alu_config.svh"

  typedef logic [`ALU_XLEN-1:0]    xlen_t;
  typedef logic [`ALU_PC_W-1:0]    pc_t;
  typedef logic [`ALU_RFIDX_W-1:0] rfidx_t;
  typedef logic [`ALU_OP_W-1:0]    op_t;

  // Instruction group from the decoder
  typedef enum logic [0:0] {
    GRP_ALU = 1'b0,
    GRP_BJP = 1'b1
  } grp_e;

  // Regular ALU ops, system ops at the top
  typedef enum logic [`ALU_OP_W-1:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    XOR    = 4'd2,
    SLL    = 4'd3,
    SRL    = 4'd4,
    SRA    = 4'd5,
    OR     = 4'd6,
    AND    = 4'd7,
    SLT    = 4'd8,
    SLTU   = 4'd9,
    LUI    = 4'd10,
    ECALL  = 4'd11,
    EBREAK = 4'd12,
    WFI    = 4'd13
  } rglr_op_e;

  typedef enum logic [`ALU_OP_W-1:0] {
    BEQ  = 4'd0,
    BNE  = 4'd1,
    BLT  = 4'd2,
    BGE  = 4'd3,
    BLTU = 4'd4,
    BGEU = 4'd5,
    JAL  = 4'd6,
    JALR = 4'd7
  } bjp_op_e;

  // Shared datapath operation
  typedef enum logic [`ALU_OP_W-1:0] {
    DP_ADD   = 4'd0,
    DP_SUB   = 4'd1,
    DP_XOR   = 4'd2,
    DP_SLL   = 4'd3,
    DP_SRL   = 4'd4,
    DP_SRA   = 4'd5,
    DP_OR    = 4'd6,
    DP_AND   = 4'd7,
    DP_SLT   = 4'd8,
    DP_SLTU  = 4'd9,
    DP_PASS2 = 4'd10
  } dp_op_e;

endpackage

//--- verilog/exu_alu_rglr.sv
`timescale 1ns/10ps

module exu_alu_rglr
  import exu_alu_pkg::*;
(
  input  logic     i_valid,
  input  rglr_op_e i_op,
  input  logic     i_op2imm,
  input  xlen_t    i_rs1,
  input  xlen_t    i_rs2,
  input  xlen_t    i_imm,
  // Datapath request
  output dp_op_e   o_dp_op,
  output xlen_t    o_dp_op1,
  output xlen_t    o_dp_op2,
  // Commit flags
  output logic     o_err,
  output logic     o_ecall,
  output logic     o_ebreak,
  output logic     o_wfi
);

  logic use_imm;

  always_comb begin
    case (i_op)
      ADD:     o_dp_op = DP_ADD;
      SUB:     o_dp_op = DP_SUB;
      XOR:     o_dp_op = DP_XOR;
      SLL:     o_dp_op = DP_SLL;
      SRL:     o_dp_op = DP_SRL;
      SRA:     o_dp_op = DP_SRA;
      OR:      o_dp_op = DP_OR;
      AND:     o_dp_op = DP_AND;
      SLT:     o_dp_op = DP_SLT;
      SLTU:    o_dp_op = DP_SLTU;
      LUI:     o_dp_op = DP_PASS2;   // Upper immediate comes in pre-shifted
      default: o_dp_op = DP_ADD;     // System ops, result is dropped
    endcase
  end

  // lui always takes the immediate, I-type ops by decode
  assign use_imm  = i_op2imm | (i_op == LUI);
  assign o_dp_op1 = i_rs1;
  assign o_dp_op2 = use_imm ? i_imm : i_rs2;

  ////////////////////////////////////////////////////////////
  // System ops
  ////////////////////////////////////////////////////////////

  assign o_ecall  = i_valid & (i_op == ECALL);
  assign o_ebreak = i_valid & (i_op == EBREAK);
  assign o_wfi    = i_valid & (i_op == WFI);

  // Trap to commit, never written back
  assign o_err = o_ecall | o_ebreak | o_wfi;

endmodule

//--- verilog/exu_alu_bjp.sv
`timescale 1ns/10ps
`include "exu_alu_config.svh"

module exu_alu_bjp
  import exu_alu_pkg::*;
(
  input  logic    i_valid,
  input  bjp_op_e i_op,
  input  xlen_t   i_rs1,
  input  xlen_t   i_rs2,
  input  pc_t     i_pc,
  // Flags back from the comparator
  input  logic    i_dp_eq,
  input  logic    i_dp_lt,
  input  logic    i_dp_ltu,
  // Link add request
  output dp_op_e  o_dp_op,
  output xlen_t   o_dp_op1,
  output xlen_t   o_dp_op2,
  // Comparator operands
  output xlen_t   o_cmp_op1,
  output xlen_t   o_cmp_op2,
  output logic    o_cmt_bjp,
  output logic    o_rslv
);

  logic taken;

  ////////////////////////////////////////////////////////////
  // Outcome
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (i_op)
      BEQ:     taken = i_dp_eq;
      BNE:     taken = ~i_dp_eq;
      BLT:     taken = i_dp_lt;
      BGE:     taken = ~i_dp_lt;
      BLTU:    taken = i_dp_ltu;
      BGEU:    taken = ~i_dp_ltu;
      default: taken = 1'b1;   // jal and jalr
    endcase
  end

  assign o_cmt_bjp = i_valid;
  assign o_rslv    = i_valid & taken;

  // Link value pc+4, target left to commit
  assign o_dp_op   = DP_ADD;
  assign o_dp_op1  = xlen_t'(i_pc);
  assign o_dp_op2  = xlen_t'(`ALU_LINK_INC);

  // rs1/rs2 go to the comparator, not the adder
  assign o_cmp_op1 = i_rs1;
  assign o_cmp_op2 = i_rs2;

  // Decoder must never hand over an op outside the table
  always_comb begin
    if (i_valid) begin
      a_legal_op: assert (i_op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR})
        else $error("Illegal bjp op %0d", i_op);
    end
  end

endmodule

//--- verilog/exu_alu_dpath.sv
`timescale 1ns/10ps
`include "exu_alu_config.svh"

module exu_alu_dpath
  import exu_alu_pkg::*;
(
  input  dp_op_e i_op,
  input  xlen_t  i_op1,
  input  xlen_t  i_op2,
  input  xlen_t  i_cmp_op1,
  input  xlen_t  i_cmp_op2,
  output xlen_t  o_res,
  output logic   o_eq,
  output logic   o_lt,
  output logic   o_ltu
);

  function automatic xlen_t bit_rev(input xlen_t v);
    xlen_t r;
    for (int k = 0; k < `ALU_XLEN; k++) begin
      r[k] = v[`ALU_XLEN-1-k];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Adder, shared by add, sub, slt and sltu
  ////////////////////////////////////////////////////////////

  logic               is_sub;
  logic               sext;
  logic [`ALU_XLEN:0] add_a;
  logic [`ALU_XLEN:0] add_b;
  logic [`ALU_XLEN:0] add_res;

  assign is_sub = (i_op == DP_SUB) | (i_op == DP_SLT) | (i_op == DP_SLTU);
  assign sext   = (i_op != DP_SLTU);   // Zero extend only for unsigned compare

  // One extra bit so the MSB of the difference is the less-than
  assign add_a   = {sext & i_op1[`ALU_XLEN-1], i_op1};
  assign add_b   = {sext & i_op2[`ALU_XLEN-1], i_op2};
  assign add_res = add_a + (is_sub ? ~add_b : add_b) + {{`ALU_XLEN{1'b0}}, is_sub};

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  // Left shifts run through the right shifter bit-reversed
  logic [4:0]         shamt;
  xlen_t              shf_src;
  logic               shf_fill;
  logic [`ALU_XLEN:0] shf_wide;
  xlen_t              shf_res;

  assign shamt    = i_op2[4:0];
  assign shf_src  = (i_op == DP_SLL) ? bit_rev(i_op1) : i_op1;
  assign shf_fill = (i_op == DP_SRA) & i_op1[`ALU_XLEN-1];   // Sign fill for sra only
  assign shf_wide = $signed({shf_fill, shf_src}) >>> shamt;
  assign shf_res  = shf_wide[`ALU_XLEN-1:0];

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (i_op)
      DP_ADD,
      DP_SUB:   o_res = add_res[`ALU_XLEN-1:0];
      DP_SLT,
      DP_SLTU:  o_res = {{(`ALU_XLEN-1){1'b0}}, add_res[`ALU_XLEN]};
      DP_SLL:   o_res = bit_rev(shf_res);
      DP_SRL,
      DP_SRA:   o_res = shf_res;
      DP_XOR:   o_res = i_op1 ^ i_op2;
      DP_OR:    o_res = i_op1 | i_op2;
      DP_AND:   o_res = i_op1 & i_op2;
      DP_PASS2: o_res = i_op2;
      default:  o_res = '0;
    endcase
  end

  // Branch comparator, separate from the adder
  assign o_eq  = (i_cmp_op1 == i_cmp_op2);
  assign o_lt  = ($signed(i_cmp_op1) < $signed(i_cmp_op2));
  assign o_ltu = (i_cmp_op1 < i_cmp_op2);

endmodule

//--- verilog/exu_alu_cmt_slot.sv
`timescale 1ns/10ps

module exu_alu_cmt_slot
  import exu_alu_pkg::*;
(
  input  logic   clk,
  input  logic   i_arst_n,
  input  logic   i_load,
  output logic   o_ready,
  // Entry in
  input  xlen_t  i_wdat,
  input  rfidx_t i_rdidx,
  input  logic   i_rdwen,
  input  logic   i_err,
  input  pc_t    i_pc,
  input  xlen_t  i_imm,
  input  logic   i_cmt_bjp,
  input  logic   i_cmt_bjp_prdt,
  input  logic   i_cmt_bjp_rslv,
  input  logic   i_cmt_ecall,
  input  logic   i_cmt_ebreak,
  input  logic   i_cmt_wfi,
  input  logic   i_cmt_ifu_ilegl,
  input  logic   i_cmt_ifu_buserr,
  input  logic   i_cmt_ifu_misalgn,
  // Commit port
  output logic   o_cmt_valid,
  input  logic   i_cmt_ready,
  output pc_t    o_cmt_pc,
  output xlen_t  o_cmt_imm,
  output logic   o_cmt_bjp,
  output logic   o_cmt_bjp_prdt,
  output logic   o_cmt_bjp_rslv,
  output logic   o_cmt_ecall,
  output logic   o_cmt_ebreak,
  output logic   o_cmt_wfi,
  output logic   o_cmt_ifu_ilegl,
  output logic   o_cmt_ifu_buserr,
  output logic   o_cmt_ifu_misalgn,
  // Write-back port
  output logic   o_wbck_valid,
  input  logic   i_wbck_ready,
  output xlen_t  o_wbck_wdat,
  output rfidx_t o_wbck_rdidx
);

  logic       full_r;
  xlen_t      wdat_r;
  rfidx_t     rdidx_r;
  logic       rdwen_r;
  logic       err_r;
  pc_t        pc_r;
  xlen_t      imm_r;
  logic [8:0] flags_r;   // bjp group, then system, then fetch
  logic       need_wbck;
  logic       fire;

  ////////////////////////////////////////////////////////////
  // Joined handshake
  ////////////////////////////////////////////////////////////

  assign need_wbck = rdwen_r & ~err_r;

  // Commit and write-back each wait on the other's ready
  assign o_cmt_valid  = full_r & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = full_r & need_wbck & i_cmt_ready;
  assign fire         = o_cmt_valid & i_cmt_ready;
  assign o_ready      = ~full_r | fire;   // Refill in the firing cycle

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full_r <= 1'b0;
    end else if (i_load) begin
      full_r <= 1'b1;
    end else if (fire) begin
      full_r <= 1'b0;
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (i_load) begin
      wdat_r  <= i_wdat;
      rdidx_r <= i_rdidx;
      rdwen_r <= i_rdwen;
      err_r   <= i_err;
      pc_r    <= i_pc;
      imm_r   <= i_imm;
      flags_r <= {i_cmt_bjp, i_cmt_bjp_prdt, i_cmt_bjp_rslv,
                  i_cmt_ecall, i_cmt_ebreak, i_cmt_wfi,
                  i_cmt_ifu_ilegl, i_cmt_ifu_buserr, i_cmt_ifu_misalgn};
    end
  end

  assign o_cmt_pc     = pc_r;
  assign o_cmt_imm    = imm_r;
  assign o_wbck_wdat  = wdat_r;
  assign o_wbck_rdidx = rdidx_r;
  assign {o_cmt_bjp, o_cmt_bjp_prdt, o_cmt_bjp_rslv,
          o_cmt_ecall, o_cmt_ebreak, o_cmt_wfi,
          o_cmt_ifu_ilegl, o_cmt_ifu_buserr, o_cmt_ifu_misalgn} = flags_r;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Trap and fetch-fault entries never reach the register file
  a_wbck_need: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_wbck_valid |-> !(|flags_r[5:0]))
    else $error("Write-back for an entry that needs none");

  // Upstream must not overwrite a held entry
  a_entry_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    full_r && !fire |=> full_r &&
      $stable({wdat_r, rdidx_r, rdwen_r, err_r, pc_r, imm_r, flags_r}))
    else $error("Commit entry changed under back-pressure");

endmodule

//--- verilog/exu_alu.sv
`timescale 1ns/10ps
`include "exu_alu_config.svh"

module exu_alu
  import exu_alu_pkg::*;
(
  input  logic   clk,
  input  logic   i_arst_n,
  // Issue side
  input  logic   i_valid,
  output logic   o_ready,
  input  grp_e   i_grp,
  input  op_t    i_op,
  input  logic   i_op2imm,
  input  xlen_t  i_rs1,
  input  xlen_t  i_rs2,
  input  xlen_t  i_imm,
  input  pc_t    i_pc,
  input  rfidx_t i_rdidx,
  input  logic   i_rdwen,
  input  logic   i_bjp_prdt,
  input  logic   i_ilegl,
  input  logic   i_buserr,
  input  logic   i_misalgn,
  // Commit port
  output logic   o_cmt_valid,
  input  logic   i_cmt_ready,
  output pc_t    o_cmt_pc,
  output xlen_t  o_cmt_imm,
  output logic   o_cmt_bjp,
  output logic   o_cmt_bjp_prdt,
  output logic   o_cmt_bjp_rslv,
  output logic   o_cmt_ecall,
  output logic   o_cmt_ebreak,
  output logic   o_cmt_wfi,
  output logic   o_cmt_ifu_ilegl,
  output logic   o_cmt_ifu_buserr,
  output logic   o_cmt_ifu_misalgn,
  // Write-back port
  output logic   o_wbck_valid,
  input  logic   i_wbck_ready,
  output xlen_t  o_wbck_wdat,
  output rfidx_t o_wbck_rdidx
);

  ////////////////////////////////////////////////////////////
  // Group decode and operand gating
  ////////////////////////////////////////////////////////////

  logic   ifu_excp;
  logic   alu_sel;
  logic   bjp_sel;
  logic   rglr_valid;
  logic   bjp_valid;

  assign ifu_excp = i_ilegl | i_buserr | i_misalgn;      // Overrides the group
  assign alu_sel  = ~ifu_excp & (i_grp == GRP_ALU);
  assign bjp_sel  = ~ifu_excp & (i_grp == GRP_BJP);

  assign rglr_valid = i_valid & alu_sel;
  assign bjp_valid  = i_valid & bjp_sel;

  // Idle unit sees zeros so its request stays quiet
  op_t    rglr_op;
  op_t    bjp_op;
  xlen_t  rglr_rs1;
  xlen_t  rglr_rs2;
  xlen_t  rglr_imm;
  xlen_t  bjp_rs1;
  xlen_t  bjp_rs2;
  pc_t    bjp_pc;

  assign rglr_op  = {`ALU_OP_W{alu_sel}} & i_op;
  assign rglr_rs1 = {`ALU_XLEN{alu_sel}} & i_rs1;
  assign rglr_rs2 = {`ALU_XLEN{alu_sel}} & i_rs2;
  assign rglr_imm = {`ALU_XLEN{alu_sel}} & i_imm;
  assign bjp_op   = {`ALU_OP_W{bjp_sel}} & i_op;
  assign bjp_rs1  = {`ALU_XLEN{bjp_sel}} & i_rs1;
  assign bjp_rs2  = {`ALU_XLEN{bjp_sel}} & i_rs2;
  assign bjp_pc   = {`ALU_PC_W{bjp_sel}} & i_pc;

  ////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////

  dp_op_e rglr_dp_op;
  xlen_t  rglr_dp_op1;
  xlen_t  rglr_dp_op2;
  logic   rglr_err;
  logic   rglr_ecall;
  logic   rglr_ebreak;
  logic   rglr_wfi;

  exu_alu_rglr u_rglr (
    .i_valid   (rglr_valid),
    .i_op      (rglr_op_e'(rglr_op)),
    .i_op2imm  (i_op2imm),
    .i_rs1     (rglr_rs1),
    .i_rs2     (rglr_rs2),
    .i_imm     (rglr_imm),
    .o_dp_op   (rglr_dp_op),
    .o_dp_op1  (rglr_dp_op1),
    .o_dp_op2  (rglr_dp_op2),
    .o_err     (rglr_err),
    .o_ecall   (rglr_ecall),
    .o_ebreak  (rglr_ebreak),
    .o_wfi     (rglr_wfi)
  );

  dp_op_e bjp_dp_op;
  xlen_t  bjp_dp_op1;
  xlen_t  bjp_dp_op2;
  xlen_t  cmp_op1;
  xlen_t  cmp_op2;
  logic   bjp_cmt;
  logic   bjp_rslv;
  logic   dp_eq;
  logic   dp_lt;
  logic   dp_ltu;

  exu_alu_bjp u_bjp (
    .i_valid   (bjp_valid),
    .i_op      (bjp_op_e'(bjp_op)),
    .i_rs1     (bjp_rs1),
    .i_rs2     (bjp_rs2),
    .i_pc      (bjp_pc),
    .i_dp_eq   (dp_eq),
    .i_dp_lt   (dp_lt),
    .i_dp_ltu  (dp_ltu),
    .o_dp_op   (bjp_dp_op),
    .o_dp_op1  (bjp_dp_op1),
    .o_dp_op2  (bjp_dp_op2),
    .o_cmp_op1 (cmp_op1),
    .o_cmp_op2 (cmp_op2),
    .o_cmt_bjp (bjp_cmt),
    .o_rslv    (bjp_rslv)
  );

  // Shared datapath request
  dp_op_e dp_op;
  xlen_t  dp_op1;
  xlen_t  dp_op2;
  xlen_t  dp_res;

  always_comb begin
    if (bjp_sel) begin
      dp_op  = bjp_dp_op;
      dp_op1 = bjp_dp_op1;
      dp_op2 = bjp_dp_op2;
    end else begin
      dp_op  = rglr_dp_op;
      dp_op1 = rglr_dp_op1;
      dp_op2 = rglr_dp_op2;
    end
  end

  exu_alu_dpath u_dpath (
    .i_op      (dp_op),
    .i_op1     (dp_op1),
    .i_op2     (dp_op2),
    .i_cmp_op1 (cmp_op1),
    .i_cmp_op2 (cmp_op2),
    .o_res     (dp_res),
    .o_eq      (dp_eq),
    .o_lt      (dp_lt),
    .o_ltu     (dp_ltu)
  );

  ////////////////////////////////////////////////////////////
  // Commit slot
  ////////////////////////////////////////////////////////////

  exu_alu_cmt_slot u_cmt_slot (
    .clk                (clk),
    .i_arst_n           (i_arst_n),
    .i_load             (i_valid & o_ready),
    .o_ready            (o_ready),
    .i_wdat             ({`ALU_XLEN{~ifu_excp}} & dp_res),
    .i_rdidx            (i_rdidx),
    .i_rdwen            (i_rdwen),
    .i_err              (ifu_excp | rglr_err),
    .i_pc               (i_pc),
    .i_imm              (i_imm),
    .i_cmt_bjp          (bjp_sel & bjp_cmt),
    .i_cmt_bjp_prdt     (bjp_sel & i_bjp_prdt),
    .i_cmt_bjp_rslv     (bjp_sel & bjp_rslv),
    .i_cmt_ecall        (alu_sel & rglr_ecall),
    .i_cmt_ebreak       (alu_sel & rglr_ebreak),
    .i_cmt_wfi          (alu_sel & rglr_wfi),
    .i_cmt_ifu_ilegl    (i_ilegl),
    .i_cmt_ifu_buserr   (i_buserr),
    .i_cmt_ifu_misalgn  (i_misalgn),
    .o_cmt_valid        (o_cmt_valid),
    .i_cmt_ready        (i_cmt_ready),
    .o_cmt_pc           (o_cmt_pc),
    .o_cmt_imm          (o_cmt_imm),
    .o_cmt_bjp          (o_cmt_bjp),
    .o_cmt_bjp_prdt     (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv     (o_cmt_bjp_rslv),
    .o_cmt_ecall        (o_cmt_ecall),
    .o_cmt_ebreak       (o_cmt_ebreak),
    .o_cmt_wfi          (o_cmt_wfi),
    .o_cmt_ifu_ilegl    (o_cmt_ifu_ilegl),
    .o_cmt_ifu_buserr   (o_cmt_ifu_buserr),
    .o_cmt_ifu_misalgn  (o_cmt_ifu_misalgn),
    .o_wbck_valid       (o_wbck_valid),
    .i_wbck_ready       (i_wbck_ready),
    .o_wbck_wdat        (o_wbck_wdat),
    .o_wbck_rdidx       (o_wbck_rdidx)
  );

  // At most one source of commit flags per instruction
  a_one_unit: assert property (@(posedge clk) disable iff (!i_arst_n)
    $onehot0({bjp_cmt, rglr_err, ifu_excp}))
    else $error("More than one unit flagged the same instruction");

endmodule

//--- tests/tb_exu_alu.sv
`timescale 1ns/10ps
`include "exu_alu_config.svh"

module tb_exu_alu
  import exu_alu_pkg::*;
();

  localparam int TIMEOUT_CYC = 20;

  logic   clk = 1'b0;
  logic   i_arst_n;
  logic   i_valid;
  logic   o_ready;
  grp_e   i_grp;
  op_t    i_op;
  logic   i_op2imm;
  xlen_t  i_rs1;
  xlen_t  i_rs2;
  xlen_t  i_imm;
  pc_t    i_pc;
  rfidx_t i_rdidx;
  logic   i_rdwen;
  logic   i_bjp_prdt;
  logic   i_ilegl;
  logic   i_buserr;
  logic   i_misalgn;
  logic   o_cmt_valid;
  logic   i_cmt_ready;
  pc_t    o_cmt_pc;
  xlen_t  o_cmt_imm;
  logic   o_cmt_bjp;
  logic   o_cmt_bjp_prdt;
  logic   o_cmt_bjp_rslv;
  logic   o_cmt_ecall;
  logic   o_cmt_ebreak;
  logic   o_cmt_wfi;
  logic   o_cmt_ifu_ilegl;
  logic   o_cmt_ifu_buserr;
  logic   o_cmt_ifu_misalgn;
  logic   o_wbck_valid;
  logic   i_wbck_ready;
  xlen_t  o_wbck_wdat;
  rfidx_t o_wbck_rdidx;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] lfsr_state = 32'haa76_93e4;

  // Expected entry, flags in slot order bjp..misalgn
  xlen_t       exp_wdat;
  logic        exp_wb;
  logic [8:0]  exp_flags;
  pc_t         exp_pc;
  xlen_t       exp_imm;
  rfidx_t      exp_rdidx;

  always #20 clk = ~clk;

  exu_alu u_exu_alu (.*);

  ////////////////////////////////////////////////////////////
  // Stimulus source and reference rules
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic xlen_t rand_word(input int nbits);
    xlen_t w;
    w = '0;
    for (int k = 0; k < nbits; k++) begin
      w = {w[30:0], rand_bit()};
    end
    return w;
  endfunction

  // RV32I integer results
  function automatic xlen_t alu_result(input rglr_op_e op, input xlen_t a, input xlen_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return $signed(a) >>> b[4:0];
      OR:      return a | b;
      AND:     return a & b;
      SLT:     return {31'b0, $signed(a) < $signed(b)};
      SLTU:    return {31'b0, a < b};
      default: return b;   // lui
    endcase
  endfunction

  function automatic logic branch_taken(input bjp_op_e op, input xlen_t a, input xlen_t b);
    case (op)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      BGEU:    return a >= b;
      default: return 1'b1;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and handshakes
  ////////////////////////////////////////////////////////////

  task automatic compare_val(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    a_val: assert (got === exp) else begin
      errors++;
      $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    a_bit: assert (got === exp) else begin
      errors++;
      $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_commit();
    compare_bit("o_cmt_valid", o_cmt_valid, 1'b1);
    compare_bit("o_wbck_valid", o_wbck_valid, exp_wb);
    compare_val("o_cmt_pc", o_cmt_pc, exp_pc);
    compare_val("o_cmt_imm", o_cmt_imm, exp_imm);
    if (exp_wb) begin
      compare_val("o_wbck_wdat", o_wbck_wdat, exp_wdat);
      compare_val("o_wbck_rdidx", 32'(o_wbck_rdidx), 32'(exp_rdidx));
    end
    compare_bit("o_cmt_bjp", o_cmt_bjp, exp_flags[8]);
    compare_bit("o_cmt_bjp_prdt", o_cmt_bjp_prdt, exp_flags[7]);
    compare_bit("o_cmt_bjp_rslv", o_cmt_bjp_rslv, exp_flags[6]);
    compare_bit("o_cmt_ecall", o_cmt_ecall, exp_flags[5]);
    compare_bit("o_cmt_ebreak", o_cmt_ebreak, exp_flags[4]);
    compare_bit("o_cmt_wfi", o_cmt_wfi, exp_flags[3]);
    compare_bit("o_cmt_ifu_ilegl", o_cmt_ifu_ilegl, exp_flags[2]);
    compare_bit("o_cmt_ifu_buserr", o_cmt_ifu_buserr, exp_flags[1]);
    compare_bit("o_cmt_ifu_misalgn", o_cmt_ifu_misalgn, exp_flags[0]);
  endtask

  task automatic drive_instr(input grp_e grp, input op_t op, input logic op2imm,
                             input xlen_t rs1, input xlen_t rs2, input xlen_t imm,
                             input pc_t pc, input logic rdwen, input logic prdt,
                             input logic [2:0] excp);
    i_valid    = 1'b1;
    i_grp      = grp;
    i_op       = op;
    i_op2imm   = op2imm;
    i_rs1      = rs1;
    i_rs2      = rs2;
    i_imm      = imm;
    i_pc       = pc;
    i_rdidx    = rfidx_t'(rand_word(5));
    i_rdwen    = rdwen;
    i_bjp_prdt = prdt;
    {i_ilegl, i_buserr, i_misalgn} = excp;
    exp_pc     = pc;
    exp_imm    = imm;
    exp_rdidx  = i_rdidx;
  endtask

  // Ends 1 ns after the accepting edge
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!o_ready && n < TIMEOUT_CYC) begin
      n++;
      @(negedge clk);
    end
    if (!o_ready) begin
      errors++;
      $display("Timed out waiting for o_ready at %0t", $time);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_commit(output int lat);
    lat = 0;
    @(negedge clk);
    while (!o_cmt_valid && lat < TIMEOUT_CYC) begin
      lat++;
      @(negedge clk);
    end
    if (!o_cmt_valid) begin
      errors++;
      $display("Timed out waiting for o_cmt_valid at %0t", $time);
    end
  endtask

  task automatic issue_one(input grp_e grp, input op_t op, input logic op2imm,
                           input xlen_t rs1, input xlen_t rs2, input xlen_t imm,
                           input pc_t pc, input logic rdwen, input logic prdt,
                           input logic [2:0] excp);
    int lat;
    @(posedge clk);
    #1;
    drive_instr(grp, op, op2imm, rs1, rs2, imm, pc, rdwen, prdt, excp);
    wait_accept();
    i_valid = 1'b0;
    wait_commit(lat);
    checks++;
    a_lat: assert (lat == 0) else begin
      errors++;
      $display("Commit came %0d cycles after the expected cycle at %0t", lat, $time);
    end
    compare_commit();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state_check();
    @(negedge clk);
    compare_bit("o_cmt_valid", o_cmt_valid, 1'b0);
    compare_bit("o_wbck_valid", o_wbck_valid, 1'b0);
    compare_bit("o_ready", o_ready, 1'b1);
  endtask

  task automatic regular_op_sweep();
    rglr_op_e op;
    xlen_t    a;
    xlen_t    b;
    xlen_t    imm;
    for (int k = 0; k <= 10; k++) begin
      for (int form = 0; form < 2; form++) begin
        op  = rglr_op_e'(k);
        a   = rand_word(32);
        b   = rand_word(32);
        imm = rand_word(32);
        exp_wdat  = alu_result(op, a, (form == 1 || op == LUI) ? imm : b);
        exp_wb    = 1'b1;
        exp_flags = '0;
        issue_one(GRP_ALU, op_t'(k), form == 1, a, b, imm,
                  pc_t'(rand_word(30) << 2), 1'b1, 1'b0, 3'b000);
      end
    end
    // No destination, commit only
    exp_wb = 1'b0;
    issue_one(GRP_ALU, op_t'(ADD), 1'b0, rand_word(32), rand_word(32), '0,
              pc_t'(rand_word(30) << 2), 1'b0, 1'b0, 3'b000);
  endtask

  task automatic branch_sweep();
    xlen_t   pa [4];
    xlen_t   pb [4];
    bjp_op_e op;
    logic    prdt;
    pc_t     pc;
    pa[0] = rand_word(32);
    pb[0] = pa[0];            // Equal
    pa[1] = 32'hffff_fffb;
    pb[1] = 32'h0000_0003;    // Signed less, unsigned greater
    pa[2] = 32'h7000_0000;
    pb[2] = 32'h0000_0010;
    pa[3] = 32'h7fff_ffff;
    pb[3] = 32'h8000_0000;    // Signed greater, unsigned less
    for (int k = 0; k < 8; k++) begin
      for (int p = 0; p < 4; p++) begin
        op   = bjp_op_e'(k);
        prdt = rand_bit();
        pc   = pc_t'(rand_word(30) << 2);
        exp_wdat  = xlen_t'(pc + 4);
        exp_wb    = (op == JAL || op == JALR);
        exp_flags = {1'b1, prdt, branch_taken(op, pa[p], pb[p]), 6'b0};
        issue_one(GRP_BJP, op_t'(k), 1'b0, pa[p], pb[p], rand_word(32), pc,
                  exp_wb, prdt, 3'b000);
      end
    end
  endtask

  task automatic trap_commits();
    exp_wb = 1'b0;
    for (int k = 0; k < 3; k++) begin
      exp_flags = 9'b1 << (5 - k);   // ecall, ebreak, wfi
      issue_one(GRP_ALU, op_t'(ECALL + k), 1'b0, rand_word(32), rand_word(32), '0,
                pc_t'(rand_word(30) << 2), 1'b1, 1'b0, 3'b000);
    end
    // Fetch faults on a predicted jal, group flags must clear
    for (int k = 0; k < 3; k++) begin
      exp_flags = 9'b100 >> k;
      issue_one(GRP_BJP, op_t'(JAL), 1'b0, rand_word(32), rand_word(32), '0,
                pc_t'(rand_word(30) << 2), 1'b1, 1'b1, 3'b100 >> k);
    end
    exp_flags = 9'b000_000_001;
    issue_one(GRP_ALU, op_t'(ECALL), 1'b0, '0, '0, '0,
              pc_t'(rand_word(30) << 2), 1'b1, 1'b0, 3'b001);
  endtask

  task automatic back_to_back_issue();
    xlen_t  a;
    xlen_t  b;
    xlen_t  c;
    pc_t    a_pc;
    rfidx_t a_idx;
    a = rand_word(32);
    b = rand_word(32);
    c = rand_word(32);
    @(posedge clk);
    #1;
    drive_instr(GRP_ALU, op_t'(ADD), 1'b0, a, b, '0, pc_t'(rand_word(30) << 2),
                1'b1, 1'b0, 3'b000);
    wait_accept();
    a_pc  = exp_pc;
    a_idx = exp_rdidx;
    drive_instr(GRP_ALU, op_t'(XOR), 1'b0, a, c, '0, pc_t'(rand_word(30) << 2),
                1'b1, 1'b0, 3'b000);
    @(negedge clk);
    compare_bit("o_cmt_valid", o_cmt_valid, 1'b1);
    compare_bit("o_ready", o_ready, 1'b1);
    compare_val("o_wbck_wdat", o_wbck_wdat, a + b);
    compare_val("o_cmt_pc", o_cmt_pc, a_pc);
    compare_val("o_wbck_rdidx", 32'(o_wbck_rdidx), 32'(a_idx));
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    @(negedge clk);
    exp_wdat  = a ^ c;
    exp_wb    = 1'b1;
    exp_flags = '0;
    compare_commit();
  endtask

  task automatic wbck_backpressure();
    xlen_t  a;
    xlen_t  b;
    pc_t    hold_pc;
    rfidx_t hold_idx;
    a = rand_word(32);
    b = rand_word(32);
    @(posedge clk);
    #1;
    i_wbck_ready = 1'b0;
    drive_instr(GRP_ALU, op_t'(OR), 1'b0, a, b, '0, pc_t'(rand_word(30) << 2),
                1'b1, 1'b0, 3'b000);
    wait_accept();
    hold_pc  = exp_pc;
    hold_idx = exp_rdidx;
    // An ecall waits on the input while the slot is held
    drive_instr(GRP_ALU, op_t'(ECALL), 1'b0, '0, '0, rand_word(32),
                pc_t'(rand_word(30) << 2), 1'b1, 1'b0, 3'b000);
    repeat (3) begin
      @(negedge clk);
      compare_bit("o_cmt_valid", o_cmt_valid, 1'b0);
      compare_bit("o_wbck_valid", o_wbck_valid, 1'b1);
      compare_bit("o_ready", o_ready, 1'b0);
      compare_val("o_wbck_wdat", o_wbck_wdat, a | b);
      compare_val("o_cmt_pc", o_cmt_pc, hold_pc);
      compare_val("o_wbck_rdidx", 32'(o_wbck_rdidx), 32'(hold_idx));
    end
    // Commit stall holds back the write-back too
    @(posedge clk);
    #1;
    i_cmt_ready = 1'b0;
    @(negedge clk);
    compare_bit("o_cmt_valid", o_cmt_valid, 1'b0);
    compare_bit("o_wbck_valid", o_wbck_valid, 1'b0);
    compare_bit("o_ready", o_ready, 1'b0);
    @(posedge clk);
    #1;
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b1;
    @(negedge clk);
    compare_bit("o_cmt_valid", o_cmt_valid, 1'b1);
    compare_bit("o_wbck_valid", o_wbck_valid, 1'b1);
    compare_bit("o_ready", o_ready, 1'b1);
    compare_val("o_wbck_wdat", o_wbck_wdat, a | b);
    @(posedge clk);
    #1;
    i_valid      = 1'b0;
    i_wbck_ready = 1'b0;   // ecall needs no write-back
    @(negedge clk);
    exp_wb    = 1'b0;
    exp_flags = 9'b000_100_000;
    compare_commit();
    @(posedge clk);
    #1;
    i_wbck_ready = 1'b1;
  endtask

  initial begin
    i_arst_n     = 1'b0;
    i_valid      = 1'b0;
    i_grp        = GRP_ALU;
    i_op         = '0;
    i_op2imm     = 1'b0;
    i_rs1        = '0;
    i_rs2        = '0;
    i_imm        = '0;
    i_pc         = '0;
    i_rdidx      = '0;
    i_rdwen      = 1'b0;
    i_bjp_prdt   = 1'b0;
    i_ilegl      = 1'b0;
    i_buserr     = 1'b0;
    i_misalgn    = 1'b0;
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    reset_state_check();
    regular_op_sweep();
    branch_sweep();
    trap_commits();
    back_to_back_issue();
    wbck_backpressure();
    repeat (2) @(posedge clk);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+verilog
verilog/exu_alu_pkg.sv
verilog/exu_alu_rglr.sv
verilog/exu_alu_bjp.sv
verilog/exu_alu_dpath.sv
verilog/exu_alu_cmt_slot.sv
verilog/exu_alu.sv
tests/tb_exu_alu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execution stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert \
  -f build.f \
  --top-module tb_exu_alu \
  -Mdir obj_dir \
  -o sim_tb_exu_alu

./obj_dir/sim_tb_exu_alu | tee "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
echo "Simulation passed"
